// File: verification/program_golden.mem
// header: program word count, trace record count, executed-instruction bound
// then the program words from reset pc, then trace records as pc, register, data
0000002e 0000001f 0000002c
// program: alu and shifts, memory, branches, bl and jirl, r0
142468a4 02bffc05 02800406 0299e084 00101887 001110c8 001218a9 001298aa
0014188b 0014948c 0015188d 0015948e 0040908f 0044f0b0 0048a111 001214d2
001294d3 02840014 29800284 29801288 28800295 28801296 29800287 28800297
580008c5 02804419 580008c6 0280881a 5c0008c6 0280cc1a 5c0008c5 0281101b
50000c00 0281541c 50000c00 0281981b 53fff7ff 54001000 0281dc1d 50001000
0282201e 0282641e 4c000022 02801400 0015001f 50000000
// trace: pc register data, two records per line
1c000000 00000004 12345000  1c000004 00000005 ffffffff
1c000008 00000006 00000001  1c00000c 00000004 12345678
1c000010 00000007 12345679  1c000014 00000008 edcba989
1c000018 00000009 00000001  1c00001c 0000000a 00000000
1c000020 0000000b edcba986  1c000024 0000000c 12345678
1c000028 0000000d 12345679  1c00002c 0000000e edcba987
1c000030 0000000f 23456780  1c000034 00000010 0000000f
1c000038 00000011 ffedcba9  1c00003c 00000012 00000000
1c000040 00000013 00000001  1c000044 00000014 00000100
1c000050 00000015 12345678  1c000054 00000016 edcba989
1c00005c 00000017 12345679  1c000064 00000019 00000011
1c000074 0000001a 00000033  1c00008c 0000001b 00000066
1c000084 0000001c 00000055  1c000094 00000001 1c000098
1c0000a4 0000001e 00000099  1c0000a8 00000002 1c0000ac
1c000098 0000001d 00000077  1c0000ac 00000000 00000005
1c0000b0 0000001f 00000000

// File: files.f
source/cpu_pkg.sv
source/inst_decoder.sv
source/alu.sv
source/regfile.sv
source/multicycle_core.sv
source/data_ram.sv
source/cpu_subsystem.sv
verification/clock_gen.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/10ps
TOP        = cpu_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam word_t base_pc     = default_reset_pc;
    localparam int    golden_size = 256;

    logic   clk;
    logic   reset;
    word_t  inst_addr;
    word_t  inst_rdata = '0;
    logic   trace_valid;
    trace_t trace;

    word_t  golden [golden_size]; // counts, program words, then trace triples.
    int     prog_count;
    int     trace_count;
    int     cycle_limit;
    int     cycles;
    int     rec_idx;
    int     rec_base;
    int     fetch_idx;

    clock_gen #(
        .period_ns    (40),
        .reset_cycles (3)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cpu_subsystem #(
        .reset_pc       (base_pc),
        .data_addr_bits (10)
    ) i_cpu_subsystem (
        .clk         (clk),
        .reset       (reset),
        .inst_addr   (inst_addr),
        .inst_rdata  (inst_rdata),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    task automatic check_value(input word_t expected, input word_t actual, input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h got %h",
                     $time, what, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // ************************************************************
    // instruction memory, one word per falling edge
    // ************************************************************
    always @(negedge clk) begin
        fetch_idx = int'((inst_addr - base_pc) >> 2);
        if (fetch_idx < prog_count) begin
            inst_rdata <= golden[3 + fetch_idx];
        end else if (reset === 1'b0) begin
            $display("Instruction fetch from %h lies outside the program", inst_addr);
            $display("Errors found");
            $fatal(1, "fetch outside the program");
        end
    end

    // ************************************************************
    // writeback trace against the golden records
    // ************************************************************
    initial begin
        $readmemh("verification/program_golden.mem", golden);
        prog_count  = int'(golden[0]);
        trace_count = int'(golden[1]);
        cycle_limit = 5 * int'(golden[2]) + 20;
        rec_base    = 3 + prog_count;
        rec_idx     = 0;
        cycles      = 0;
        if (trace_count == 0 || rec_base + 3 * trace_count > golden_size) begin
            $display("The golden file is missing or its counts do not fit the buffer");
            $display("Errors found");
            $fatal(1, "bad golden file");
        end else begin
            @(negedge reset);
            check_value(base_pc, inst_addr, "first fetch address");
            check_value(32'd0, {31'b0, trace_valid}, "trace_valid out of reset");
            while (rec_idx < trace_count) begin
                @(negedge clk);
                cycles = cycles + 1;
                if (cycles > cycle_limit) begin
                    $display("The trace did not complete: %0d of %0d records in %0d cycles",
                             rec_idx, trace_count, cycle_limit);
                    $display("Errors found");
                    $fatal(1, "timeout");
                end else if (trace_valid) begin
                    check_value(golden[rec_base + 3 * rec_idx], trace.pc, "trace pc");
                    check_value(golden[rec_base + 3 * rec_idx + 1], {27'b0, trace.wnum},
                                "trace register");
                    check_value(golden[rec_base + 3 * rec_idx + 2], trace.wdata,
                                "trace data");
                    rec_idx = rec_idx + 1;
                end
            end
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // released on a falling edge, half a cycle before the core sees it.
    end

endmodule

`default_nettype wire

// File: source/cpu_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_subsystem #(
    parameter cpu_pkg::word_t reset_pc       = cpu_pkg::default_reset_pc,
    parameter int             data_addr_bits = 10
) (
    input  wire                 clk,
    input  wire                 reset,
    output cpu_pkg::word_t      inst_addr,
    input  wire cpu_pkg::word_t inst_rdata,
    output logic                trace_valid,
    output cpu_pkg::trace_t     trace
);
    import cpu_pkg::*;

    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_we;

    multicycle_core #(
        .reset_pc (reset_pc)
    ) u_core (
        .clk         (clk),
        .reset       (reset),
        .inst_addr   (inst_addr),
        .inst_rdata  (inst_rdata),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_we     (data_we),
        .data_rdata  (data_rdata),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    data_ram #(
        .data_addr_bits (data_addr_bits)
    ) u_data_ram (
        .clk   (clk),
        .addr  (data_addr),
        .wdata (data_wdata),
        .we    (data_we),
        .rdata (data_rdata)
    );

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int data_addr_bits = 10
) (
    input  wire                 clk,
    input  wire cpu_pkg::word_t addr,
    input  wire cpu_pkg::word_t wdata,
    input  wire                 we,
    output cpu_pkg::word_t      rdata
);
    import cpu_pkg::*;

    word_t                     mem [2**data_addr_bits];
    logic [data_addr_bits-1:0] word_idx;

    assign word_idx = addr[data_addr_bits+1:2]; // byte address down to word index.

    always_ff @(posedge clk) begin
        if (we)
            mem[word_idx] <= wdata;
        rdata <= mem[word_idx];
    end

    a_word_aligned: assert property (@(posedge clk)
        we |-> (addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: source/multicycle_core.sv
`timescale 1ns/10ps
`default_nettype none

module multicycle_core #(
    parameter cpu_pkg::word_t reset_pc = cpu_pkg::default_reset_pc
) (
    input  wire                 clk,
    input  wire                 reset,
    output cpu_pkg::word_t      inst_addr,
    input  wire cpu_pkg::word_t inst_rdata,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_wdata,
    output logic                data_we,
    input  wire cpu_pkg::word_t data_rdata,
    output logic                trace_valid,
    output cpu_pkg::trace_t     trace
);
    import cpu_pkg::*;

    core_state_t state;
    core_state_t state_next;
    decode_t     dec;
    decode_t     dec_q;
    word_t       pc;
    word_t       inst_pc;
    word_t       rj_value;
    word_t       rkd_value;
    word_t       src1_q;
    word_t       src2_q;
    word_t       store_q;
    word_t       alu_result;
    word_t       alu_res_q;
    word_t       br_target;
    word_t       wb_data;
    reg_idx_t    raddr2;
    logic        br_taken;

    assign inst_addr = pc;
    assign raddr2    = dec.src2_from_rd ? inst_rdata[4:0] : inst_rdata[14:10];

    inst_decoder u_decoder (
        .inst (inst_rdata),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst_rdata[9:5]),
        .rdata1 (rj_value),
        .raddr2 (raddr2),
        .rdata2 (rkd_value),
        .we     (trace_valid),
        .waddr  (dec_q.dest),
        .wdata  (wb_data)
    );

    alu u_alu (
        .op     (dec_q.alu_op),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    // ********************************************************
    // branch decision, valid while the word sits in st_decode
    // ********************************************************
    assign br_taken  = dec.is_jump_pc | dec.is_jirl
                     | (dec.is_branch_cond & (dec.is_beq == (rj_value == rkd_value)));
    assign br_target = (dec.is_jirl ? rj_value : pc) + dec.br_offs;

    always_comb begin
        case (state)
            st_fetch:     state_next = st_decode;
            st_decode:    state_next = (dec.reg_write | dec.mem_write) ? st_execute : st_fetch;
            st_execute:   state_next = (dec_q.is_load | dec_q.mem_write) ? st_memory
                                                                         : st_writeback;
            st_memory:    state_next = dec_q.is_load ? st_writeback : st_fetch;
            default:      state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_fetch;
            pc      <= reset_pc;
            data_we <= 1'b0;
        end else begin
            state   <= state_next;
            data_we <= (state == st_execute) && dec_q.mem_write; // high for st_memory only.
            if (state == st_decode)
                pc <= br_taken ? br_target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec_q   <= dec;
            inst_pc <= pc;
            src1_q  <= dec.src1_is_pc ? pc : rj_value;
            src2_q  <= dec.src2_is_imm ? dec.imm : rkd_value;
            store_q <= rkd_value;
        end
        if (state == st_execute) begin
            alu_res_q  <= alu_result;
            data_addr  <= alu_result;
            data_wdata <= store_q;
        end
    end

    // the RAM returns the load word one cycle after the address, so it lands in writeback.
    assign wb_data     = dec_q.res_from_mem ? data_rdata : alu_res_q;
    assign trace_valid = (state == st_writeback) && dec_q.reg_write;
    assign trace.pc    = inst_pc;
    assign trace.wnum  = dec_q.dest;
    assign trace.wdata = wb_data;

    a_we_in_memory: assert property (@(posedge clk) disable iff (reset)
        data_we |-> (state == st_memory));

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {st_fetch, st_decode, st_execute, st_memory, st_writeback});

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire                    clk,
    input  wire cpu_pkg::reg_idx_t raddr1,
    output cpu_pkg::word_t         rdata1,
    input  wire cpu_pkg::reg_idx_t raddr2,
    output cpu_pkg::word_t         rdata2,
    input  wire                    we,
    input  wire cpu_pkg::reg_idx_t waddr,
    input  wire cpu_pkg::word_t    wdata
);
    import cpu_pkg::*;

    word_t regs [1:31]; // r0 is hardwired and has no storage.

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0))
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::word_t   src1,
    input  wire cpu_pkg::word_t   src2,
    output cpu_pkg::word_t        result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = word_t'($signed(src1) >>> shamt);
            alu_lui:  result = src2;            // the decoder already shifted the immediate.
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  wire cpu_pkg::word_t   inst,
    output cpu_pkg::decode_t      dec
);
    import cpu_pkg::*;

    logic op_3r;
    logic op_shift;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic src2_is_4;
    logic [25:0] i26;

    // ********************************************************
    // opcode match
    // ********************************************************
    assign op_3r    = (inst[31:26] == 6'h00) && (inst[25:22] == 4'h0) && (inst[21:20] == 2'h1);
    assign op_shift = (inst[31:26] == 6'h00) && (inst[25:22] == 4'h1) && (inst[21:20] == 2'h0);

    assign inst_add_w   = op_3r && (inst[19:15] == 5'h00);
    assign inst_sub_w   = op_3r && (inst[19:15] == 5'h02);
    assign inst_slt     = op_3r && (inst[19:15] == 5'h04);
    assign inst_sltu    = op_3r && (inst[19:15] == 5'h05);
    assign inst_nor     = op_3r && (inst[19:15] == 5'h08);
    assign inst_and     = op_3r && (inst[19:15] == 5'h09);
    assign inst_or      = op_3r && (inst[19:15] == 5'h0a);
    assign inst_xor     = op_3r && (inst[19:15] == 5'h0b);
    assign inst_slli_w  = op_shift && (inst[19:15] == 5'h01);
    assign inst_srli_w  = op_shift && (inst[19:15] == 5'h09);
    assign inst_srai_w  = op_shift && (inst[19:15] == 5'h11);
    assign inst_addi_w  = (inst[31:26] == 6'h00) && (inst[25:22] == 4'ha);
    assign inst_ld_w    = (inst[31:26] == 6'h0a) && (inst[25:22] == 4'h2);
    assign inst_st_w    = (inst[31:26] == 6'h0a) && (inst[25:22] == 4'h6);
    assign inst_jirl    = (inst[31:26] == 6'h13);
    assign inst_b       = (inst[31:26] == 6'h14);
    assign inst_bl      = (inst[31:26] == 6'h15);
    assign inst_beq     = (inst[31:26] == 6'h16);
    assign inst_bne     = (inst[31:26] == 6'h17);
    assign inst_lu12i_w = (inst[31:26] == 6'h05) && !inst[25];

    assign src2_is_4 = inst_jirl | inst_bl; // link value is pc plus 4.
    assign i26       = {inst[9:0], inst[25:10]};

    // ********************************************************
    // control and immediates
    // ********************************************************
    always_comb begin
        dec = '0;
        case (1'b1)
            inst_sub_w:   dec.alu_op = alu_sub;
            inst_slt:     dec.alu_op = alu_slt;
            inst_sltu:    dec.alu_op = alu_sltu;
            inst_and:     dec.alu_op = alu_and;
            inst_nor:     dec.alu_op = alu_nor;
            inst_or:      dec.alu_op = alu_or;
            inst_xor:     dec.alu_op = alu_xor;
            inst_slli_w:  dec.alu_op = alu_sll;
            inst_srli_w:  dec.alu_op = alu_srl;
            inst_srai_w:  dec.alu_op = alu_sra;
            inst_lu12i_w: dec.alu_op = alu_lui;
            default:      dec.alu_op = alu_add; // address and link sums use add too.
        endcase

        dec.src1_is_pc     = inst_jirl | inst_bl;
        dec.src2_is_imm    = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                           | inst_ld_w | inst_st_w | inst_lu12i_w | src2_is_4;
        dec.src2_from_rd   = inst_beq | inst_bne | inst_st_w;
        dec.res_from_mem   = inst_ld_w;
        dec.is_load        = inst_ld_w;
        dec.mem_write      = inst_st_w;
        dec.reg_write      = op_3r & (inst_add_w | inst_sub_w | inst_slt | inst_sltu
                           | inst_nor | inst_and | inst_or | inst_xor)
                           | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                           | inst_lu12i_w | inst_ld_w | inst_jirl | inst_bl;
        dec.is_branch_cond = inst_beq | inst_bne;
        dec.is_beq         = inst_beq;
        dec.is_jump_pc     = inst_b | inst_bl;
        dec.is_jirl        = inst_jirl;
        dec.dest           = inst_bl ? 5'd1 : inst[4:0];

        if (src2_is_4)
            dec.imm = 32'd4;
        else if (inst_lu12i_w)
            dec.imm = {inst[24:5], 12'b0};
        else if (op_shift)
            dec.imm = {27'b0, inst[14:10]};
        else
            dec.imm = {{20{inst[21]}}, inst[21:10]};

        if (inst_b | inst_bl)
            dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        else
            dec.br_offs = {{14{inst[25]}}, inst[25:10], 2'b0};
    end

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t default_reset_pc = 32'h1c000000;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } core_state_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     src2_from_rd;   // stores and branches read rd as the second operand.
        logic     res_from_mem;
        logic     reg_write;
        logic     mem_write;
        logic     is_load;
        logic     is_branch_cond;
        logic     is_beq;         // cleared for bne.
        logic     is_jump_pc;
        logic     is_jirl;
        reg_idx_t dest;
        word_t    imm;
        word_t    br_offs;
    } decode_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t wnum;
        word_t    wdata;
    } trace_t;

endpackage

`default_nettype wire
